//--- verilog/seq_isa_pkg.sv
// Instruction-side definitions shared by the dispatcher and the sequencer.
// Opcodes are grouped by functional unit, so the decoder sorts them by range.
// A new opcode must be placed inside the range of its unit.
// The vm bit follows the vector ISA convention, where set means unmasked.

package seq_isa_pkg;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // ALU ops first, then multiplier, then memory
  typedef enum logic [3:0] {
    VADD  = 4'd0,
    VSUB  = 4'd1,
    VAND  = 4'd2,
    VOR   = 4'd3,
    VMUL  = 4'd4,
    VMACC = 4'd5,
    VLE   = 4'd6,
    VSE   = 4'd7
  } vop_e;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  // 32 architectural vector registers
  typedef logic [4:0] vreg_t;

  // Masked ops read their mask from v0
  localparam vreg_t VMASK = 5'd0;

  // Dispatcher request, 20 bits
  typedef struct packed {
    vop_e  op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    logic  vm;
  } seq_req_t;

endpackage

//--- verilog/seq_cfg_pkg.sv
// Machine-side definitions of the sequencer.
// Instruction IDs, functional units, queue depths and the issued request.
// NrVInsn must stay a power of two so that every vid_t value names an ID.
// QueueDepth is ordered as vfu_e.

package seq_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Instructions in flight
  ////////////////////////////////////////////////////////////

  localparam int unsigned NrVInsn = 8;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  // One bit per instruction ID
  typedef logic [NrVInsn-1:0] vid_mask_t;

  ////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    VFU_ALU   = 2'd0,
    VFU_MUL   = 2'd1,
    VFU_LOAD  = 2'd2,
    VFU_STORE = 2'd3
  } vfu_e;

  localparam int unsigned NrVfus = 4;

  // Queue slots per unit, indexed by vfu_e
  localparam int unsigned QueueDepth [NrVfus] = '{4, 4, 2, 2};

  // Decoder output
  typedef struct packed {
    vfu_e              vfu;
    logic              use_vs1;
    logic              use_vs2;
    logic              use_vd;
    logic [NrVfus-1:0] target;
  } decoded_t;

  // Request issued to the units, hazards are one bit per older ID
  typedef struct packed {
    vid_t               id;
    seq_isa_pkg::vop_e  op;
    vfu_e               vfu;
    seq_isa_pkg::vreg_t vd;
    seq_isa_pkg::vreg_t vs1;
    seq_isa_pkg::vreg_t vs2;
    logic               vm;
    vid_mask_t          hazard_vs1;
    vid_mask_t          hazard_vs2;
    vid_mask_t          hazard_vm;
    vid_mask_t          hazard_vd;
  } pe_req_t;

endpackage

//--- verilog/insn_decoder.sv
// Opcode decoder of the sequencer, purely combinational.
// Opcodes outside the named set decode to the ALU with no operand use.
// The vd read of VMACC needs no flag of its own: VMACC also writes vd,
// so the WAW check on vd already orders it behind the older writer.

`timescale 1ns/100ps

module insn_decoder (
  input  seq_isa_pkg::vop_e     op_i,
  output seq_cfg_pkg::decoded_t dec_o
);

  always_comb begin : p_decode
    // Default to ALU with nothing read or written
    dec_o     = '0;
    dec_o.vfu = seq_cfg_pkg::VFU_ALU;

    case (op_i) inside
      // Two sources, one destination
      [seq_isa_pkg::VADD:seq_isa_pkg::VOR]: begin
        dec_o.vfu     = seq_cfg_pkg::VFU_ALU;
        dec_o.use_vs1 = 1'b1;
        dec_o.use_vs2 = 1'b1;
        dec_o.use_vd  = 1'b1;
      end
      // Multiply and multiply-accumulate
      [seq_isa_pkg::VMUL:seq_isa_pkg::VMACC]: begin
        dec_o.vfu     = seq_cfg_pkg::VFU_MUL;
        dec_o.use_vs1 = 1'b1;
        dec_o.use_vs2 = 1'b1;
        dec_o.use_vd  = 1'b1;
      end
      // Load fills vd from memory
      seq_isa_pkg::VLE: begin
        dec_o.vfu    = seq_cfg_pkg::VFU_LOAD;
        dec_o.use_vd = 1'b1;
      end
      // Store drains vs2 to memory
      seq_isa_pkg::VSE: begin
        dec_o.vfu     = seq_cfg_pkg::VFU_STORE;
        dec_o.use_vs2 = 1'b1;
      end
      default: ;
    endcase

    // One-hot copy of the unit, used for queue bookkeeping
    for (int u = 0; u < seq_cfg_pkg::NrVfus; u++) begin
      dec_o.target[u] = (dec_o.vfu == seq_cfg_pkg::vfu_e'(u));
    end
  end

endmodule

//--- verilog/unit_queue_counter.sv
// Outstanding-instruction counter of one functional unit.
// Done pulses must only name instructions issued to this unit.
// Several done bits in one cycle retire a single entry.

`timescale 1ns/100ps

module unit_queue_counter #(
  parameter int unsigned Depth = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   issue_i,
  input  seq_cfg_pkg::vid_mask_t done_i,
  output logic                   full_o
);

  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic [CntWidth-1:0] cnt_q;
  logic                retire;

  // Any finished ID frees one slot
  assign retire = |done_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (issue_i && !retire) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (retire && !issue_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
    // Issue and retire together leave the count unchanged
  end

  // Ready upstream looks at this before the increment lands
  assign full_o = (cnt_q == CntWidth'(Depth));

endmodule

//--- verilog/issue_scoreboard.sv
// Issue scoreboard of the vector sequencer.
// Each register remembers only its latest reader and latest writer.
// A done pulse invalidates list entries and hazards at once, and the ID
// itself is free for allocation from the next cycle.
// The issued request is a one-cycle strobe with no back-pressure.

`timescale 1ns/100ps

module issue_scoreboard (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  seq_isa_pkg::seq_req_t                            req_i,
  input  logic                                             req_valid_i,
  input  seq_cfg_pkg::decoded_t                            dec_i,
  input  logic [seq_cfg_pkg::NrVfus-1:0]                   unit_full_i,
  input  seq_cfg_pkg::vid_mask_t [seq_cfg_pkg::NrVfus-1:0] pe_done_i,
  output logic                                             req_ready_o,
  output logic [seq_cfg_pkg::NrVfus-1:0]                   unit_issue_o,
  output seq_cfg_pkg::pe_req_t                             pe_req_o,
  output logic                                             pe_req_valid_o,
  output seq_cfg_pkg::vid_mask_t                           running_o,
  output seq_cfg_pkg::vid_mask_t [seq_cfg_pkg::NrVInsn-1:0] hazard_table_o,
  output logic                                             idle_o
);

  // Who touches a register, and whether that ID still runs
  typedef struct packed {
    seq_cfg_pkg::vid_t vid;
    logic              valid;
  } vreg_access_t;

  vreg_access_t [31:0] read_list_d, read_list_q;
  vreg_access_t [31:0] write_list_d, write_list_q;
  logic [31:0]         rd_live, wr_live;

  seq_cfg_pkg::vid_mask_t running_d, running_q;
  seq_cfg_pkg::vid_mask_t done_all, still_running;
  seq_cfg_pkg::vid_mask_t [seq_cfg_pkg::NrVInsn-1:0] table_d, table_q;

  seq_cfg_pkg::vid_t      next_id;
  logic                   all_busy;
  seq_cfg_pkg::vid_mask_t hz_vs1, hz_vs2, hz_vm, hz_vd;
  logic                   no_operands, hazard_stall, unit_blocked, accept;
  seq_cfg_pkg::pe_req_t   pe_req_d;

  ////////////////////////////////////////////////////////////
  // Retirement and ID allocation
  ////////////////////////////////////////////////////////////

  // Merge the done pulses of all units
  always_comb begin : p_done
    done_all = '0;
    for (int u = 0; u < seq_cfg_pkg::NrVfus; u++) begin
      done_all |= pe_done_i[u];
    end
  end

  assign still_running = running_q & ~done_all;

  // Lowest free ID wins, scanned from the top down
  always_comb begin : p_next_id
    next_id = '0;
    for (int i = seq_cfg_pkg::NrVInsn - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        next_id = seq_cfg_pkg::vid_t'(i);
      end
    end
  end

  assign all_busy = &running_q;

  // List entries whose owner is retiring count as gone
  always_comb begin : p_live
    for (int v = 0; v < 32; v++) begin
      rd_live[v] = read_list_q[v].valid & still_running[read_list_q[v].vid];
      wr_live[v] = write_list_q[v].valid & still_running[write_list_q[v].vid];
    end
  end

  ////////////////////////////////////////////////////////////
  // Hazard vectors of the incoming request
  ////////////////////////////////////////////////////////////

  always_comb begin : p_hazards
    hz_vs1 = '0;
    hz_vs2 = '0;
    hz_vm  = '0;
    hz_vd  = '0;

    // RAW on sources and mask
    if (dec_i.use_vs1 && wr_live[req_i.vs1]) hz_vs1[write_list_q[req_i.vs1].vid] = 1'b1;
    if (dec_i.use_vs2 && wr_live[req_i.vs2]) hz_vs2[write_list_q[req_i.vs2].vid] = 1'b1;
    if (!req_i.vm && wr_live[seq_isa_pkg::VMASK]) begin
      hz_vm[write_list_q[seq_isa_pkg::VMASK].vid] = 1'b1;
    end

    // WAR, the new result must not overtake any operand fetch of the reader
    if (dec_i.use_vd && rd_live[req_i.vd]) begin
      hz_vs1[read_list_q[req_i.vd].vid] = 1'b1;
      hz_vs2[read_list_q[req_i.vd].vid] = 1'b1;
      hz_vm[read_list_q[req_i.vd].vid]  = 1'b1;
    end

    // WAW
    if (dec_i.use_vd && wr_live[req_i.vd]) hz_vd[write_list_q[req_i.vd].vid] = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Ready and accept
  ////////////////////////////////////////////////////////////

  // Ops with no vector source cannot chain, so they wait out every hazard
  assign no_operands  = !dec_i.use_vs1 && !dec_i.use_vs2 && req_i.vm;
  assign hazard_stall = no_operands && (|{hz_vs1, hz_vs2, hz_vm, hz_vd});
  // Only the target unit's queue can block
  assign unit_blocked = |(dec_i.target & unit_full_i);

  assign req_ready_o  = !unit_blocked && !all_busy && !hazard_stall;
  assign accept       = req_valid_i && req_ready_o;
  assign unit_issue_o = accept ? dec_i.target : '0;

  ////////////////////////////////////////////////////////////
  // State update
  ////////////////////////////////////////////////////////////

  always_comb begin : p_update
    read_list_d  = read_list_q;
    write_list_d = write_list_q;
    running_d    = still_running;
    table_d      = table_q;

    // Drop entries of retiring instructions
    for (int v = 0; v < 32; v++) begin
      read_list_d[v].valid  = rd_live[v];
      write_list_d[v].valid = wr_live[v];
    end

    if (accept) begin
      running_d[next_id] = 1'b1;
      // Record this ID as the newest writer and reader
      if (dec_i.use_vd) write_list_d[req_i.vd] = '{vid: next_id, valid: 1'b1};
      if (dec_i.use_vs1) read_list_d[req_i.vs1] = '{vid: next_id, valid: 1'b1};
      if (dec_i.use_vs2) read_list_d[req_i.vs2] = '{vid: next_id, valid: 1'b1};
      if (!req_i.vm) read_list_d[seq_isa_pkg::VMASK] = '{vid: next_id, valid: 1'b1};
      // Row holds every older ID this one waits on
      table_d[next_id] = hz_vs1 | hz_vs2 | hz_vm | hz_vd;
    end

    // Clear columns of finished instructions
    for (int id = 0; id < seq_cfg_pkg::NrVInsn; id++) begin
      table_d[id] &= running_d;
    end
  end

  // Request as seen by the units one cycle later
  always_comb begin : p_pe_req
    pe_req_d = '{
      id        : next_id,
      op        : req_i.op,
      vfu       : dec_i.vfu,
      vd        : req_i.vd,
      vs1       : req_i.vs1,
      vs2       : req_i.vs2,
      vm        : req_i.vm,
      hazard_vs1: hz_vs1,
      hazard_vs2: hz_vs2,
      hazard_vm : hz_vm,
      hazard_vd : hz_vd
    };
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q      <= '0;
      read_list_q    <= '0;
      write_list_q   <= '0;
      table_q        <= '0;
      pe_req_valid_o <= 1'b0;
    end else begin
      running_q      <= running_d;
      read_list_q    <= read_list_d;
      write_list_q   <= write_list_d;
      table_q        <= table_d;
      pe_req_valid_o <= accept;
    end
  end

  // Payload only moves on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pe_req_o <= pe_req_d;
    end
  end

  assign running_o      = running_q;
  assign hazard_table_o = table_q;
  assign idle_o         = ~|running_q;

endmodule

//--- verilog/vinsn_sequencer.sv
// Top level of the vector instruction sequencer.
// The dispatcher must hold req_i stable until req_ready_o is seen high.
// Each unit pulses the IDs it finished on its own pe_done_i entry.
// Queue depths come from the machine package, one counter per unit.

`timescale 1ns/100ps

module vinsn_sequencer (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // Dispatcher side
  input  seq_isa_pkg::seq_req_t                             req_i,
  input  logic                                              req_valid_i,
  output logic                                              req_ready_o,
  // Unit side
  input  seq_cfg_pkg::vid_mask_t [seq_cfg_pkg::NrVfus-1:0]  pe_done_i,
  output seq_cfg_pkg::pe_req_t                              pe_req_o,
  output logic                                              pe_req_valid_o,
  output seq_cfg_pkg::vid_mask_t                            running_o,
  output seq_cfg_pkg::vid_mask_t [seq_cfg_pkg::NrVInsn-1:0] hazard_table_o,
  output logic                                              idle_o
);

  seq_cfg_pkg::decoded_t              dec;
  logic [seq_cfg_pkg::NrVfus-1:0]     unit_issue;
  logic [seq_cfg_pkg::NrVfus-1:0]     unit_full;

  // Unit and operand use straight from the opcode
  insn_decoder i_decoder (
    .op_i (req_i.op),
    .dec_o(dec)
  );

  ////////////////////////////////////////////////////////////
  // Per-unit queue counters
  ////////////////////////////////////////////////////////////

  for (genvar u = 0; u < seq_cfg_pkg::NrVfus; u++) begin : gen_unit_cnt
    unit_queue_counter #(
      .Depth(seq_cfg_pkg::QueueDepth[u])
    ) i_cnt (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .issue_i(unit_issue[u]),
      .done_i (pe_done_i[u]),
      .full_o (unit_full[u])
    );
  end

  // Hazards, IDs and the issue register
  issue_scoreboard i_scoreboard (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .dec_i         (dec),
    .unit_full_i   (unit_full),
    .pe_done_i     (pe_done_i),
    .req_ready_o   (req_ready_o),
    .unit_issue_o  (unit_issue),
    .pe_req_o      (pe_req_o),
    .pe_req_valid_o(pe_req_valid_o),
    .running_o     (running_o),
    .hazard_table_o(hazard_table_o),
    .idle_o        (idle_o)
  );

endmodule

//--- test/tb_vinsn_sequencer.sv
// Directed testbench of the vector instruction sequencer.
// Every test starts and ends with no instruction in flight.
// Inputs change on the falling edge and ready is read shortly after.
// One done pulse retires one queue entry, so IDs retire one per pulse.

`timescale 1ns/100ps

module tb_vinsn_sequencer;

  // Whole run takes well under 100 cycles
  localparam int MaxCycles = 2000;

  logic clk_i, rst_ni, req_valid, req_ready, pe_req_valid, idle;
  seq_isa_pkg::seq_req_t                             req;
  seq_cfg_pkg::vid_mask_t [seq_cfg_pkg::NrVfus-1:0]  pe_done;
  seq_cfg_pkg::pe_req_t                              pe_req;
  seq_cfg_pkg::vid_mask_t                            running;
  seq_cfg_pkg::vid_mask_t [seq_cfg_pkg::NrVInsn-1:0] hazard_table;

  integer seed = 35;
  int     cycles = 0;
  int     checks = 0;
  int     errors = 0;
  int     err_at_start;
  string  test_name;

  vinsn_sequencer dut0 (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req), .req_valid_i(req_valid),
    .req_ready_o(req_ready), .pe_done_i(pe_done), .pe_req_o(pe_req),
    .pe_req_valid_o(pe_req_valid), .running_o(running),
    .hazard_table_o(hazard_table), .idle_o(idle)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout after %0d cycles, the DUT stopped accepting or issuing", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks and expected values
  ////////////////////////////////////////////////////////////

  task automatic check_req(string what, seq_cfg_pkg::pe_req_t exp, seq_cfg_pkg::pe_req_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_mask(string what, seq_cfg_pkg::vid_mask_t exp,
                            seq_cfg_pkg::vid_mask_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // Unit of each opcode as the ISA groups them
  function automatic seq_cfg_pkg::vfu_e unit_of(seq_isa_pkg::vop_e op);
    case (op)
      seq_isa_pkg::VMUL, seq_isa_pkg::VMACC: return seq_cfg_pkg::VFU_MUL;
      seq_isa_pkg::VLE: return seq_cfg_pkg::VFU_LOAD;
      seq_isa_pkg::VSE: return seq_cfg_pkg::VFU_STORE;
      default: return seq_cfg_pkg::VFU_ALU;
    endcase
  endfunction

  function automatic seq_isa_pkg::seq_req_t make_req(seq_isa_pkg::vop_e op, int vd, int vs1,
                                                     int vs2, logic vm);
    return '{op: op, vd: vd[4:0], vs1: vs1[4:0], vs2: vs2[4:0], vm: vm};
  endfunction

  function automatic seq_cfg_pkg::pe_req_t expect_req(seq_isa_pkg::seq_req_t r, int id,
      seq_cfg_pkg::vid_mask_t h1, seq_cfg_pkg::vid_mask_t h2,
      seq_cfg_pkg::vid_mask_t hm, seq_cfg_pkg::vid_mask_t hd);
    return '{id: id[2:0], op: r.op, vfu: unit_of(r.op), vd: r.vd, vs1: r.vs1, vs2: r.vs2,
             vm: r.vm, hazard_vs1: h1, hazard_vs2: h2, hazard_vm: hm, hazard_vd: hd};
  endfunction

  // Source register in v1..v8
  function automatic int rand_src();
    logic [31:0] r;
    r = $random(seed);
    return 1 + r[2:0];
  endfunction

  // Bit k of every hazard-table row
  function automatic seq_cfg_pkg::vid_mask_t column_of(int k);
    seq_cfg_pkg::vid_mask_t col;
    for (int r = 0; r < seq_cfg_pkg::NrVInsn; r++) col[r] = hazard_table[r][k];
    return col;
  endfunction

  ////////////////////////////////////////////////////////////
  // Driving tasks
  ////////////////////////////////////////////////////////////

  // Called on a falling edge, returns on the falling edge of the pulse cycle
  task automatic issue(input seq_isa_pkg::seq_req_t r, output seq_cfg_pkg::pe_req_t got);
    req       = r;
    req_valid = 1'b1;
    #1;
    while (!req_ready) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    req_valid = 1'b0;
    check_bit("pe_req_valid after accept", 1'b1, pe_req_valid);
    got = pe_req;
  endtask

  task automatic retire(seq_cfg_pkg::vfu_e u, seq_cfg_pkg::vid_mask_t ids);
    pe_done[u] = ids;
    @(negedge clk_i);
    pe_done = '0;
  endtask

  // Ready stays low and the last pulse does not repeat
  task automatic wait_blocked(int n, string why);
    repeat (n) begin
      #1;
      check_bit(why, 1'b0, req_ready);
      @(negedge clk_i);
      check_bit("pe_req_valid while blocked", 1'b0, pe_req_valid);
    end
  endtask

  task automatic begin_test(string name);
    test_name    = name;
    err_at_start = errors;
  endtask

  task automatic end_test();
    check_bit("idle at end", 1'b1, idle);
    $display("%s: %s", test_name, (errors == err_at_start) ? "pass" : "fail");
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_and_ids();
    seq_isa_pkg::seq_req_t r;
    seq_cfg_pkg::pe_req_t  got;
    begin_test("reset_and_ids");
    check_bit("idle after reset", 1'b1, idle);
    check_mask("running after reset", '0, running);
    check_bit("pe_req_valid after reset", 1'b0, pe_req_valid);
    for (int k = 0; k < 3; k++) begin
      // Sources v1..v8 never meet destinations v16..v18
      r = make_req(seq_isa_pkg::vop_e'(k), 16 + k, rand_src(), rand_src(), 1'b1);
      issue(r, got);
      check_req("independent ALU", expect_req(r, k, '0, '0, '0, '0), got);
      check_bit("idle while busy", 1'b0, idle);
    end
    check_mask("running", 8'h07, running);
    for (int k = 0; k < 3; k++) retire(seq_cfg_pkg::VFU_ALU, 8'(1 << k));
    end_test();
  endtask

  task automatic test_raw();
    seq_isa_pkg::seq_req_t a, b;
    seq_cfg_pkg::pe_req_t  got;
    begin_test("raw");
    a = make_req(seq_isa_pkg::VADD, 5, 1, 2, 1'b1);
    b = make_req(seq_isa_pkg::VMUL, 6, 3, 5, 1'b1);
    issue(a, got);
    check_req("writer", expect_req(a, 0, '0, '0, '0, '0), got);
    issue(b, got);
    check_req("reader of v5", expect_req(b, 1, '0, 8'h01, '0, '0), got);
    check_mask("table row 1", 8'h01, hazard_table[1]);
    retire(seq_cfg_pkg::VFU_ALU, 8'h01);
    retire(seq_cfg_pkg::VFU_MUL, 8'h02);
    end_test();
  endtask

  task automatic test_war_waw();
    seq_isa_pkg::seq_req_t a, b, c;
    seq_cfg_pkg::pe_req_t  got;
    begin_test("war_waw");
    a = make_req(seq_isa_pkg::VADD, 10, 11, 12, 1'b1);
    b = make_req(seq_isa_pkg::VSUB, 11, 13, 14, 1'b1);
    c = make_req(seq_isa_pkg::VOR, 10, 15, 16, 1'b1);
    issue(a, got);
    check_req("first", expect_req(a, 0, '0, '0, '0, '0), got);
    // b overwrites v11 which a still reads
    issue(b, got);
    check_req("war", expect_req(b, 1, 8'h01, 8'h01, 8'h01, '0), got);
    // c overwrites v10 which a writes
    issue(c, got);
    check_req("waw", expect_req(c, 2, '0, '0, '0, 8'h01), got);
    check_mask("column 0 while running", 8'h06, column_of(0));
    retire(seq_cfg_pkg::VFU_ALU, 8'h01);
    check_mask("column 0 after done", '0, column_of(0));
    retire(seq_cfg_pkg::VFU_ALU, 8'h02);
    retire(seq_cfg_pkg::VFU_ALU, 8'h04);
    end_test();
  endtask

  task automatic test_queue_full();
    seq_isa_pkg::seq_req_t r;
    seq_cfg_pkg::pe_req_t  got;
    begin_test("queue_full");
    for (int k = 0; k < 2; k++) begin
      r = make_req(seq_isa_pkg::VLE, 20 + k, 0, 0, 1'b1);
      issue(r, got);
      check_req("load", expect_req(r, k, '0, '0, '0, '0), got);
    end
    r         = make_req(seq_isa_pkg::VLE, 22, 0, 0, 1'b1);
    req       = r;
    req_valid = 1'b1;
    wait_blocked(3, "ready with load queue full");
    // The count drops only after the pulse cycle
    retire(seq_cfg_pkg::VFU_LOAD, 8'h01);
    issue(r, got);
    check_req("third load", expect_req(r, 0, '0, '0, '0, '0), got);
    retire(seq_cfg_pkg::VFU_LOAD, 8'h02);
    retire(seq_cfg_pkg::VFU_LOAD, 8'h01);
    end_test();
  endtask

  task automatic test_id_exhaustion();
    seq_isa_pkg::seq_req_t r;
    seq_cfg_pkg::pe_req_t  got;
    seq_isa_pkg::vop_e     op;
    begin_test("id_exhaustion");
    // Four ALU, two MUL, one load and one store fill all IDs
    // The load queue keeps a free slot for the blocked load
    for (int k = 0; k < 8; k++) begin
      if (k < 4) op = seq_isa_pkg::VADD;
      else if (k < 6) op = seq_isa_pkg::VMUL;
      else if (k == 6) op = seq_isa_pkg::VLE;
      else op = seq_isa_pkg::VSE;
      r = make_req(op, 1 + k, 16 + k, 16 + k, 1'b1);
      issue(r, got);
      check_req("fill", expect_req(r, k, '0, '0, '0, '0), got);
    end
    check_mask("all running", 8'hff, running);
    r         = make_req(seq_isa_pkg::VLE, 30, 0, 0, 1'b1);
    req       = r;
    req_valid = 1'b1;
    wait_blocked(2, "ready with all IDs running");
    retire(seq_cfg_pkg::VFU_MUL, 8'h10);
    issue(r, got);
    check_req("reused ID", expect_req(r, 4, '0, '0, '0, '0), got);
    for (int k = 0; k < 4; k++) retire(seq_cfg_pkg::VFU_ALU, 8'(1 << k));
    retire(seq_cfg_pkg::VFU_MUL, 8'h20);
    retire(seq_cfg_pkg::VFU_LOAD, 8'h40);
    retire(seq_cfg_pkg::VFU_LOAD, 8'h10);
    retire(seq_cfg_pkg::VFU_STORE, 8'h80);
    end_test();
  endtask

  task automatic test_load_stall();
    seq_isa_pkg::seq_req_t a, b;
    seq_cfg_pkg::pe_req_t  got;
    begin_test("load_stall");
    a = make_req(seq_isa_pkg::VADD, 3, 9, 10, 1'b1);
    b = make_req(seq_isa_pkg::VLE, 9, 0, 0, 1'b1);
    issue(a, got);
    check_req("reader of v9", expect_req(a, 0, '0, '0, '0, '0), got);
    req       = b;
    req_valid = 1'b1;
    wait_blocked(3, "ready of load over live reader");
    // Withdrawn so that the load is sent only once the reader is gone
    req_valid = 1'b0;
    retire(seq_cfg_pkg::VFU_ALU, 8'h01);
    issue(b, got);
    check_req("load after reader", expect_req(b, 0, '0, '0, '0, '0), got);
    retire(seq_cfg_pkg::VFU_LOAD, 8'h01);
    end_test();
  endtask

  initial begin
    rst_ni    = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    pe_done   = '0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_reset_and_ids();
    test_raw();
    test_war_waw();
    test_queue_full();
    test_id_exhaustion();
    test_load_stall();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
verilog/seq_isa_pkg.sv
verilog/seq_cfg_pkg.sv
verilog/insn_decoder.sv
verilog/unit_queue_counter.sv
verilog/issue_scoreboard.sv
verilog/vinsn_sequencer.sv
test/tb_vinsn_sequencer.sv

//--- Bender.yml
package:
  name: vinsn_sequencer

sources:
  - verilog/seq_isa_pkg.sv
  - verilog/seq_cfg_pkg.sv
  - verilog/insn_decoder.sv
  - verilog/unit_queue_counter.sv
  - verilog/issue_scoreboard.sv
  - verilog/vinsn_sequencer.sv
  - target: test
    files:
      - test/tb_vinsn_sequencer.sv
